//--- filelist.f
verilog/rv_pkg.sv
verilog/rv_rf_if.sv
verilog/rv_control_fsm.sv
verilog/rv_pc_counter.sv
verilog/rv_reg_file.sv
verilog/rv_imm_gen.sv
verilog/rv_alu.sv
verilog/rv_core_top.sv
testbench/rv_isa_props.sv
testbench/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/rv_rf_if.sv
      - verilog/rv_control_fsm.sv
      - verilog/rv_pc_counter.sv
      - verilog/rv_reg_file.sv
      - verilog/rv_imm_gen.sv
      - verilog/rv_alu.sv
      - verilog/rv_core_top.sv
  - target: test
    files:
      - testbench/rv_isa_props.sv
      - testbench/rv_core_tb.sv

//--- testbench/rv_core_tb.sv
module rv_core_tb import rv_pkg::*; ();

	logic              clk_i;
	logic              rst_n_i;
	logic [XLEN-1:0]   instr_i;
	logic              fetch_o;
	logic [XLEN-1:0]   pc_o;
	logic              wb_valid_o;
	logic [REG_AW-1:0] wb_rd_o;
	logic [XLEN-1:0]   wb_data_o;

	logic [XLEN-1:0]   lcg_q;
	logic [XLEN-1:0]   shadow [0:31];
	// expected values, read by the bound checker
	logic [XLEN-1:0]   exp_pc;
	logic              exp_we;
	logic [REG_AW-1:0] exp_rd;
	logic [XLEN-1:0]   exp_data;
	// fields of the word currently on instr_i
	int                cur_kind;
	logic [REG_AW-1:0] cur_rd;
	logic [REG_AW-1:0] cur_rs1;
	logic [REG_AW-1:0] cur_rs2;
	logic [XLEN-1:0]   cur_imm;
	int                timeout_errs;

	rv_core_top UUT (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.instr_i    (instr_i),
		.fetch_o    (fetch_o),
		.pc_o       (pc_o),
		.wb_valid_o (wb_valid_o),
		.wb_rd_o    (wb_rd_o),
		.wb_data_o  (wb_data_o)
	);

	bind rv_core_top rv_isa_props u_props (.*);

	initial begin
		clk_i = 1'b0;
		forever begin
			#20 clk_i = ~clk_i;
		end
	end

	function automatic logic [XLEN-1:0] next_random();
		lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
		return lcg_q;
	endfunction

	// one of add, addi, beq, jal or an unsupported word
	task automatic make_instr(output logic [XLEN-1:0] word);
		logic [XLEN-1:0] r;
		r = next_random();
		cur_kind = r[31:24] % 5;
		// x0..x7 only, so beq sees equal operands now and then
		cur_rd  = {2'b00, r[2:0]};
		cur_rs1 = {2'b00, r[5:3]};
		cur_rs2 = {2'b00, r[8:6]};
		r = next_random();
		case (cur_kind)
			0: begin
				cur_imm = '0;
				word = {7'b0000000, cur_rs2, cur_rs1, 3'b000, cur_rd, 7'b0110011};
			end
			1: begin
				cur_imm = {{20{r[11]}}, r[11:0]};
				word = {r[11:0], cur_rs1, 3'b000, cur_rd, 7'b0010011};
			end
			2: begin
				// word multiple offsets keep pc aligned
				cur_imm = {{19{r[12]}}, r[12:2], 2'b00};
				word = {cur_imm[12], cur_imm[10:5], cur_rs2, cur_rs1, 3'b000,
				        cur_imm[4:1], cur_imm[11], 7'b1100011};
			end
			3: begin
				cur_imm = {{11{r[20]}}, r[20:2], 2'b00};
				word = {cur_imm[20], cur_imm[10:1], cur_imm[11], cur_imm[19:12],
				        cur_rd, 7'b1101111};
			end
			default: begin
				// load opcode, not implemented
				cur_imm = '0;
				word = {r[31:7], 7'b0000011};
			end
		endcase
	endtask

	// isa semantics of the word on instr_i, fetched at exp_pc
	task automatic retire_model(output logic [XLEN-1:0] next_pc);
		exp_we   = 1'b0;
		exp_rd   = cur_rd;
		exp_data = '0;
		next_pc  = exp_pc + 32'd4;
		case (cur_kind)
			0: begin
				exp_we   = (cur_rd != '0);
				exp_data = shadow[cur_rs1] + shadow[cur_rs2];
			end
			1: begin
				exp_we   = (cur_rd != '0);
				exp_data = shadow[cur_rs1] + cur_imm;
			end
			2: begin
				if (shadow[cur_rs1] == shadow[cur_rs2]) begin
					next_pc = exp_pc + cur_imm;
				end
			end
			3: begin
				exp_we   = (cur_rd != '0);
				exp_data = exp_pc + 32'd4;
				next_pc  = exp_pc + cur_imm;
			end
			default: begin
			end
		endcase
		if (exp_we) begin
			shadow[cur_rd] = exp_data;
		end
	endtask

	// falling edge sampling, fetch_o is settled there
	task automatic wait_fetch(output logic seen);
		seen = 1'b0;
		for (int i = 0; i < 8 && !seen; i++) begin
			@(negedge clk_i);
			seen = (fetch_o === 1'b1);
		end
		if (!seen) begin
			timeout_errs++;
			$display("timeout: fetch strobe not seen within 8 cycles");
		end
	endtask

	initial begin
		logic [XLEN-1:0] next_word;
		logic [XLEN-1:0] next_pc;
		logic            ok;
		lcg_q        = 32'hbd7ccb0b;
		timeout_errs = 0;
		exp_pc       = '0;
		exp_we       = 1'b0;
		exp_rd       = '0;
		exp_data     = '0;
		ok           = 1'b0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		rst_n_i = 1'b0;
		make_instr(next_word);
		instr_i = next_word;
		repeat (8) @(posedge clk_i);
		rst_n_i <= 1'b1;
		for (int n = 0; n < 400; n++) begin
			wait_fetch(ok);
			if (!ok) begin
				break;
			end
			retire_model(next_pc);
			make_instr(next_word);
			// word latched here
			@(posedge clk_i);
			exp_pc = next_pc;
			// end of exec, next word stays put through wb and fetch
			@(posedge clk_i);
			instr_i <= next_word;
		end
		if (ok) begin
			// last retire plus the pc of the fetch after it
			wait_fetch(ok);
			@(posedge clk_i);
			@(posedge clk_i);
		end
		$display("errors: assertion=%0d timeout=%0d", UUT.u_props.fail_count, timeout_errs);
		if (UUT.u_props.fail_count == 0 && timeout_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- testbench/rv_isa_props.sv
module rv_isa_props import rv_pkg::*; (
	input logic              clk_i,
	input logic              rst_n_i,
	input logic              fetch_o,
	input logic [XLEN-1:0]   pc_o,
	input logic              wb_valid_o,
	input logic [REG_AW-1:0] wb_rd_o,
	input logic [XLEN-1:0]   wb_data_o
);

	// phase of the running instruction, tracked apart from the core
	core_state_e phase_q;
	int          fail_count = 0;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			phase_q <= ST_FETCH;
		end else begin
			case (phase_q)
				ST_FETCH: phase_q <= ST_EXEC;
				ST_EXEC:  phase_q <= ST_WB;
				default:  phase_q <= ST_FETCH;
			endcase
		end
	end

	function automatic void log_mismatch(string sig, logic [XLEN-1:0] exp_v,
	                                     logic [XLEN-1:0] got_v, core_state_e ph);
		fail_count++;
		$error("Fail %s exp=%h got=%h in %s", sig, exp_v, got_v, ph.name());
	endfunction

	// first cycle out of reset
	a_reset_pc: assert property (@(posedge clk_i) $rose(rst_n_i) |-> pc_o == '0)
		else log_mismatch("pc_o", '0, $sampled(pc_o), $sampled(phase_q));
	a_reset_wb: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !wb_valid_o)
		else log_mismatch("wb_valid_o", '0, $sampled(wb_valid_o), $sampled(phase_q));

	// fetch strobe once every three cycles
	a_fetch_rhythm: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		fetch_o == (phase_q == ST_FETCH))
		else log_mismatch("fetch_o", $sampled(phase_q == ST_FETCH), $sampled(fetch_o),
		                  $sampled(phase_q));

	// fetch address against the model pc
	a_fetch_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		fetch_o |-> pc_o == rv_core_tb.exp_pc)
		else log_mismatch("pc_o", $sampled(rv_core_tb.exp_pc), $sampled(pc_o),
		                  $sampled(phase_q));

	// write strobe only in writeback, and only when the model expects one
	a_wb_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_valid_o == ((phase_q == ST_WB) && rv_core_tb.exp_we))
		else log_mismatch("wb_valid_o", $sampled((phase_q == ST_WB) && rv_core_tb.exp_we),
		                  $sampled(wb_valid_o), $sampled(phase_q));

	a_wb_rd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_valid_o |-> wb_rd_o == rv_core_tb.exp_rd)
		else log_mismatch("wb_rd_o", $sampled(rv_core_tb.exp_rd), $sampled(wb_rd_o),
		                  $sampled(phase_q));

	a_wb_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_valid_o |-> wb_data_o == rv_core_tb.exp_data)
		else log_mismatch("wb_data_o", $sampled(rv_core_tb.exp_data), $sampled(wb_data_o),
		                  $sampled(phase_q));

endmodule

//--- verilog/rv_core_top.sv
module rv_core_top import rv_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic [XLEN-1:0]   instr_i,
	output logic              fetch_o,
	output logic [XLEN-1:0]   pc_o,
	output logic              wb_valid_o,
	output logic [REG_AW-1:0] wb_rd_o,
	output logic [XLEN-1:0]   wb_data_o
);

	rv_instr_u       instr_q;
	alu_op_e         alu_op;
	imm_sel_e        imm_sel;
	logic            alu_eq;
	logic            pc_load;
	logic            pc_step;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] alu_result;

	// register file port bundle
	rv_rf_if rf_bus ();

	rv_control_fsm u_ctrl (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.instr_i    (instr_i),
		.rf         (rf_bus.ctrl),
		.alu_op_o   (alu_op),
		.imm_sel_o  (imm_sel),
		.alu_eq_i   (alu_eq),
		.pc_load_o  (pc_load),
		.pc_step_o  (pc_step),
		.fetch_o    (fetch_o),
		.wb_valid_o (wb_valid_o),
		.instr_o    (instr_q)
	);

	// branch and jump offsets come straight from imm_gen
	rv_pc_counter u_pc (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.pc_load_i (pc_load),
		.pc_step_i (pc_step),
		.offset_i  (imm),
		.pc_o      (pc_o)
	);

	rv_reg_file u_rf (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.rf      (rf_bus.rf)
	);

	rv_imm_gen u_imm (
		.instr_i   (instr_q),
		.imm_sel_i (imm_sel),
		.imm_o     (imm)
	);

	rv_alu u_alu (
		.op_i     (alu_op),
		.rs1_i    (rf_bus.rs1_data),
		.rs2_i    (rf_bus.rs2_data),
		.imm_i    (imm),
		.pc_i     (pc_o),
		.result_o (alu_result),
		.eq_o     (alu_eq)
	);

	// write data is always the alu result
	assign rf_bus.rd_data = alu_result;

	// writeback observation ports
	assign wb_rd_o   = rf_bus.rd_addr;
	assign wb_data_o = rf_bus.rd_data;

endmodule

//--- verilog/rv_alu.sv
module rv_alu import rv_pkg::*; (
	input  alu_op_e         op_i,
	input  logic [XLEN-1:0] rs1_i,
	input  logic [XLEN-1:0] rs2_i,
	input  logic [XLEN-1:0] imm_i,
	input  logic [XLEN-1:0] pc_i,
	output logic [XLEN-1:0] result_o,
	output logic            eq_o
);

	logic [XLEN-1:0] sum_rr;
	logic [XLEN-1:0] sum_ri;
	logic [XLEN-1:0] link;

	// wraparound adds, no overflow flag in rv32i
	assign sum_rr = rs1_i + rs2_i;
	assign sum_ri = rs1_i + imm_i;
	// return address for jal
	assign link   = pc_i + XLEN'(4);

	// beq compare, always live
	assign eq_o = (rs1_i == rs2_i);

	always_comb begin
		case (op_i)
			ALU_ADD_RR: result_o = sum_rr;
			ALU_ADD_RI: result_o = sum_ri;
			// flag only, never written back
			ALU_CMP_EQ: result_o = {{(XLEN-1){1'b0}}, eq_o};
			default:    result_o = link;
		endcase
	end

endmodule

//--- verilog/rv_imm_gen.sv
module rv_imm_gen import rv_pkg::*; (
	input  rv_instr_u       instr_i,
	input  imm_sel_e        imm_sel_i,
	output logic [XLEN-1:0] imm_o
);

	logic [11:0] imm_i;
	logic [12:0] imm_b;
	logic [20:0] imm_j;

	// i-type, contiguous 12 bits
	assign imm_i = instr_i.i_fmt.imm;

	// b-type, bit 0 implied zero
	assign imm_b = {instr_i.b_fmt.imm_12, instr_i.b_fmt.imm_11,
	                instr_i.b_fmt.imm_10_5, instr_i.b_fmt.imm_4_1, 1'b0};

	// j-type, same idea, 21 bits
	assign imm_j = {instr_i.j_fmt.imm_20, instr_i.j_fmt.imm_19_12,
	                instr_i.j_fmt.imm_11, instr_i.j_fmt.imm_10_1, 1'b0};

	// sign extension from the top bit of each field
	always_comb begin
		case (imm_sel_i)
			IMM_B:   imm_o = {{(XLEN-13){imm_b[12]}}, imm_b};
			IMM_J:   imm_o = {{(XLEN-21){imm_j[20]}}, imm_j};
			default: imm_o = {{(XLEN-12){imm_i[11]}}, imm_i};
		endcase
	end

endmodule

//--- verilog/rv_reg_file.sv
module rv_reg_file import rv_pkg::*; (
	input logic clk_i,
	input logic rst_n_i,
	rv_rf_if.rf rf
);

	localparam int NREGS = 2 ** REG_AW;

	// x0 has no storage
	logic [XLEN-1:0] regs_q [1:NREGS-1];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < NREGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (rf.rd_we && (rf.rd_addr != '0)) begin
			regs_q[rf.rd_addr] <= rf.rd_data;
		end
	end

	// combinational reads
	always_comb begin
		if (rf.rs1_addr == '0) begin
			rf.rs1_data = '0;
		end else begin
			rf.rs1_data = regs_q[rf.rs1_addr];
		end
	end

	always_comb begin
		if (rf.rs2_addr == '0) begin
			rf.rs2_data = '0;
		end else begin
			rf.rs2_data = regs_q[rf.rs2_addr];
		end
	end

endmodule

//--- verilog/rv_pc_counter.sv
module rv_pc_counter import rv_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            pc_load_i,
	input  logic            pc_step_i,
	input  logic [XLEN-1:0] offset_i,
	output logic [XLEN-1:0] pc_o
);

	logic [XLEN-1:0] pc_q;

	// relative target, offset is pc relative for beq and jal
	logic [XLEN-1:0] pc_target;
	logic [XLEN-1:0] pc_next_seq;

	assign pc_target   = pc_q + offset_i;
	assign pc_next_seq = pc_q + XLEN'(4);

	// both strobes only ever arrive in writeback
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pc_q <= '0;
		end else if (pc_load_i) begin
			pc_q <= pc_target;
		end else if (pc_step_i) begin
			pc_q <= pc_next_seq;
		end
	end

	assign pc_o = pc_q;

	// load has priority over step
	// two strobes at once would lose one update
	a_pc_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(pc_load_i && pc_step_i));

	// word alignment relies on imm_gen offsets being multiples of 4
	a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pc_q[1:0] == 2'b00);

endmodule

//--- verilog/rv_control_fsm.sv
module rv_control_fsm import rv_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  rv_instr_u instr_i,
	rv_rf_if.ctrl     rf,
	output alu_op_e   alu_op_o,
	output imm_sel_e  imm_sel_o,
	input  logic      alu_eq_i,
	output logic      pc_load_o,
	output logic      pc_step_o,
	output logic      fetch_o,
	output logic      wb_valid_o,
	output rv_instr_u instr_o
);

	core_state_e state_q;
	core_state_e state_d;
	rv_instr_u   instr_q;
	logic        is_add;
	logic        is_addi;
	logic        is_beq;
	logic        is_jal;
	logic        writes_rd;
	logic        in_wb;

	// fetch -> exec -> wb, one step per clock
	always_comb begin
		case (state_q)
			ST_FETCH: state_d = ST_EXEC;
			ST_EXEC:  state_d = ST_WB;
			default:  state_d = ST_FETCH;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= ST_FETCH;
		end else begin
			state_q <= state_d;
		end
	end

	// instruction word captured at the end of fetch
	always_ff @(posedge clk_i) begin
		if (state_q == ST_FETCH) begin
			instr_q <= instr_i;
		end
	end

	// full decode, anything else retires as a no-op
	assign is_add  = (instr_q.r_fmt.opcode == OPCODE_R_TYPE) &&
	                 (instr_q.r_fmt.funct3 == FUNCT3_ADD) &&
	                 (instr_q.r_fmt.funct7 == FUNCT7_ADD);
	assign is_addi = (instr_q.i_fmt.opcode == OPCODE_I_TYPE) &&
	                 (instr_q.i_fmt.funct3 == FUNCT3_ADD);
	assign is_beq  = (instr_q.b_fmt.opcode == OPCODE_B_TYPE) &&
	                 (instr_q.b_fmt.funct3 == FUNCT3_BEQ);
	assign is_jal  = (instr_q.j_fmt.opcode == OPCODE_J_TYPE);

	always_comb begin
		alu_op_o  = ALU_ADD_RR;
		imm_sel_o = IMM_I;
		if (is_addi) begin
			alu_op_o = ALU_ADD_RI;
		end else if (is_beq) begin
			alu_op_o  = ALU_CMP_EQ;
			imm_sel_o = IMM_B;
		end else if (is_jal) begin
			alu_op_o  = ALU_LINK;
			imm_sel_o = IMM_J;
		end
	end

	// rs/rd sit at the same bits in every format
	assign rf.rs1_addr = instr_q.r_fmt.rs1;
	assign rf.rs2_addr = instr_q.r_fmt.rs2;
	assign rf.rd_addr  = instr_q.r_fmt.rd;

	// x0 destinations never count as a write
	assign writes_rd  = (is_add || is_addi || is_jal) && (instr_q.r_fmt.rd != '0);
	assign in_wb      = (state_q == ST_WB);
	assign rf.rd_we   = in_wb && writes_rd;
	assign wb_valid_o = in_wb && writes_rd;

	// taken beq and jal load the target, all else steps by 4
	assign pc_load_o = in_wb && (is_jal || (is_beq && alu_eq_i));
	assign pc_step_o = in_wb && !(is_jal || (is_beq && alu_eq_i));

	assign fetch_o = (state_q == ST_FETCH);
	assign instr_o = instr_q;

	// no back-pressure on instr_i
	// fetched word must be fully driven
	a_instr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		fetch_o |-> !$isunknown(instr_i));

endmodule

//--- verilog/rv_rf_if.sv
interface rv_rf_if import rv_pkg::*; ();

	// read side, addresses come from the latched instruction
	logic [REG_AW-1:0] rs1_addr;
	logic [REG_AW-1:0] rs2_addr;
	logic [XLEN-1:0]   rs1_data;
	logic [XLEN-1:0]   rs2_data;

	// write side
	logic [REG_AW-1:0] rd_addr;
	logic              rd_we;
	logic [XLEN-1:0]   rd_data;

	// sequencer picks registers and write enable
	modport ctrl (
		output rs1_addr, rs2_addr, rd_addr, rd_we
	);

	// register array
	modport rf (
		input  rs1_addr, rs2_addr, rd_addr, rd_we, rd_data,
		output rs1_data, rs2_data
	);

	// core level, feeds the alu result back as write data
	modport wdata (
		input  rs1_data, rs2_data, rd_addr, rd_we,
		output rd_data
	);

endinterface

//--- verilog/rv_pkg.sv
package rv_pkg;

	// datapath width, fixed by rv32i
	localparam int XLEN = 32;
	// register index width
	localparam int REG_AW = 5;

	// major opcodes of the four supported instructions
	localparam logic [6:0] OPCODE_R_TYPE = 7'b0110011;
	localparam logic [6:0] OPCODE_I_TYPE = 7'b0010011;
	localparam logic [6:0] OPCODE_B_TYPE = 7'b1100011;
	localparam logic [6:0] OPCODE_J_TYPE = 7'b1101111;

	// funct fields for add / addi / beq, all zero
	localparam logic [2:0] FUNCT3_ADD = 3'b000;
	localparam logic [2:0] FUNCT3_BEQ = 3'b000;
	localparam logic [6:0] FUNCT7_ADD = 7'b0000000;

	typedef struct packed {
		logic [6:0]        funct7;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]       imm;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} i_fmt_t;

	// branch offset is scattered over both ends of the word
	typedef struct packed {
		logic              imm_12;
		logic [5:0]        imm_10_5;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [3:0]        imm_4_1;
		logic              imm_11;
		logic [6:0]        opcode;
	} b_fmt_t;

	typedef struct packed {
		logic              imm_20;
		logic [9:0]        imm_10_1;
		logic              imm_11;
		logic [7:0]        imm_19_12;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} j_fmt_t;

	// one instruction word, four decodings
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		b_fmt_t b_fmt;
		j_fmt_t j_fmt;
	} rv_instr_u;

	typedef enum logic [1:0] {
		ALU_ADD_RR = 2'd0,
		ALU_ADD_RI = 2'd1,
		ALU_CMP_EQ = 2'd2,
		ALU_LINK   = 2'd3
	} alu_op_e;

	typedef enum logic [1:0] {
		IMM_I = 2'd0,
		IMM_B = 2'd1,
		IMM_J = 2'd2
	} imm_sel_e;

	typedef enum logic [1:0] {
		ST_FETCH = 2'd0,
		ST_EXEC  = 2'd1,
		ST_WB    = 2'd2
	} core_state_e;

endpackage
